// File: design/rvc_settings.svh
// ------------------------------------------------------------
// RVC expander build settings
// FPU option and instruction widths
// ------------------------------------------------------------

`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// Single-precision C.FLW/C.FSW/C.FLWSP/C.FSWSP legal when set
`define RVC_FPU_ENABLE 1'b0

// Compressed instruction width
`define RVC_CLEN 16

// Expanded base instruction width
`define RVC_ILEN 32

`endif

// File: design/rvc_pkg.sv
// ------------------------------------------------------------
// RVC expander package
// Compressed word layouts and RV32 base encoding constants
// ------------------------------------------------------------

`include "rvc_settings.svh"

package rvc_pkg;

    // ------------------------------------------------------------
    // Compressed word views
    // ------------------------------------------------------------

    // CI / CR layout
    typedef struct packed {
        logic [`RVC_CLEN-1:`RVC_CLEN-3] funct3; // Bits 15:13
        logic                           imm_hi; // Bit 12, sign or funct4 lsb
        logic [4:0]                     rd_rs1; // Bits 11:7
        logic [4:0]                     lo;     // Bits 6:2, rs2 or immediate
        logic [1:0]                     quad;
    } ci_fmt_t;

    // CL / CS / CIW / CB layout
    typedef struct packed {
        logic [`RVC_CLEN-1:`RVC_CLEN-3] funct3; // Bits 15:13
        logic [2:0]                     imm_hi; // Bits 12:10
        logic [2:0]                     rs1_p;  // Bits 9:7, primed rs1
        logic [1:0]                     imm_lo; // Bits 6:5
        logic [2:0]                     rd_rs2_p; // Bits 4:2, primed rd or rs2
        logic [1:0]                     quad;
    } cs_fmt_t;

    // One word, two decodings
    typedef union packed {
        ci_fmt_t ci;
        cs_fmt_t cs;
    } rvc_word_u;

    // ------------------------------------------------------------
    // Base opcodes
    // ------------------------------------------------------------
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    // funct3 values
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_add = 3'b000; // Also ADDI and SUB
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_sr  = 3'b101; // SRL/SRA by funct7
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // SUB, SRA

    localparam logic [11:0] f12_ebreak = 12'h001;

    // Fixed registers
    localparam logic [4:0] reg_zero = 5'd0;
    localparam logic [4:0] reg_ra   = 5'd1;
    localparam logic [4:0] reg_sp   = 5'd2;

    // Primed 3-bit register -> x8..x15
    localparam logic [1:0] prime_base = 2'b01;

endpackage

// File: design/rvc_quadrant0.sv
// ------------------------------------------------------------
// RVC quadrant 0 expander
// C.ADDI4SPN and register-based word loads/stores
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_quadrant0 (
    input  rvc_pkg::rvc_word_u     ci_word_i,
    output logic [`RVC_ILEN-1:0]   instr32_o,
    output logic                   illegal_o
);

    import rvc_pkg::*;

    logic [4:0] rs1_p;   // Base register, x8..x15
    logic [4:0] rd_p;    // Load rd or store rs2
    logic [6:0] mem_off; // Word-scaled offset
    logic [9:0] nzuimm;  // ADDI4SPN immediate

    assign rs1_p = {prime_base, ci_word_i.cs.rs1_p};
    assign rd_p  = {prime_base, ci_word_i.cs.rd_rs2_p};

    // offset[6] = bit 5, [5:3] = bits 12:10, [2] = bit 6
    assign mem_off = {ci_word_i.cs.imm_lo[0], ci_word_i.cs.imm_hi,
                      ci_word_i.cs.imm_lo[1], 2'b00};

    // nzuimm[9:6] = bits 10:7, [5:4] = bits 12:11, [3] = bit 5, [2] = bit 6
    assign nzuimm = {ci_word_i.cs.imm_hi[0], ci_word_i.cs.rs1_p,
                     ci_word_i.cs.imm_hi[2:1], ci_word_i.cs.imm_lo[0],
                     ci_word_i.cs.imm_lo[1], 2'b00};

    // ------------------------------------------------------------
    // Expansion
    // ------------------------------------------------------------
    always_comb begin
        instr32_o = '0;
        illegal_o = 1'b0;

        unique case (ci_word_i.cs.funct3)
            3'b010, 3'b011: begin // C.LW / C.FLW
                instr32_o = {5'b00000, mem_off, rs1_p, f3_lw, rd_p, opc_load};
                if ((ci_word_i.cs.funct3 == 3'b011) && (`RVC_FPU_ENABLE == 1'b0)) begin
                    illegal_o = 1'b1;
                end
            end

            3'b110, 3'b111: begin // C.SW / C.FSW
                instr32_o = {5'b00000, mem_off[6:5], rd_p, rs1_p, f3_sw,
                             mem_off[4:0], opc_store};
                if ((ci_word_i.cs.funct3 == 3'b111) && (`RVC_FPU_ENABLE == 1'b0)) begin
                    illegal_o = 1'b1;
                end
            end

            default: begin // C.ADDI4SPN, rest reserved
                instr32_o = {2'b00, nzuimm, reg_sp, f3_add, rd_p, opc_op_imm};

                // Zero immediate covers the all-zero word
                if ((nzuimm == '0) ||
                    (ci_word_i.cs.funct3 == 3'b001) || // C.FLD
                    (ci_word_i.cs.funct3 == 3'b100) || // Reserved
                    (ci_word_i.cs.funct3 == 3'b101)) begin // C.FSD
                    illegal_o = 1'b1;
                end
            end
        endcase
    end

endmodule

// File: design/rvc_quadrant1.sv
// ------------------------------------------------------------
// RVC quadrant 1 expander
// Immediates, jumps, branches and the compressed ALU group
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_quadrant1 (
    input  rvc_pkg::rvc_word_u     ci_word_i,
    output logic [`RVC_ILEN-1:0]   instr32_o,
    output logic                   illegal_o
);

    import rvc_pkg::*;

    logic        sbit;   // Bit 12
    logic [4:0]  rfield; // Bits 11:7
    logic [4:0]  lfield; // Bits 6:2
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;
    logic [11:0] imm12;  // Sign-extended 6-bit immediate
    logic [19:0] imm20;  // LUI upper immediate
    logic [11:0] imm16sp;
    logic [20:0] jimm;
    logic [12:0] bimm;

    assign sbit   = ci_word_i.ci.imm_hi;
    assign rfield = ci_word_i.ci.rd_rs1;
    assign lfield = ci_word_i.ci.lo;
    assign rs1_p  = {prime_base, ci_word_i.cs.rs1_p};
    assign rs2_p  = {prime_base, ci_word_i.cs.rd_rs2_p};

    assign imm12 = {{7{sbit}}, lfield};
    assign imm20 = {{15{sbit}}, lfield};

    // nzimm[9] = b12, [8:7] = b4:3, [6] = b5, [5] = b2, [4] = b6
    assign imm16sp = {{3{sbit}}, lfield[2:1], lfield[3], lfield[0], lfield[4], 4'b0000};

    // ------------------------------------------------------------
    // Jump and branch offsets
    // ------------------------------------------------------------

    // off[10] = b8, [9:8] = b10:9, [7] = b6, [6] = b7, [5] = b2, [4] = b11, [3:1] = b5:3
    assign jimm = {{10{sbit}}, rfield[1], rfield[3:2], lfield[4], rfield[0],
                   lfield[0], rfield[4], lfield[3:1], 1'b0};

    // off[7:6] = b6:5, [5] = b2, [4:3] = b11:10, [2:1] = b4:3
    assign bimm = {{5{sbit}}, lfield[4:3], lfield[0], rfield[4:3], lfield[2:1], 1'b0};

    // ------------------------------------------------------------
    // Expansion
    // ------------------------------------------------------------
    always_comb begin
        instr32_o = '0;
        illegal_o = 1'b0;

        unique case (ci_word_i.ci.funct3)
            3'b001, 3'b101: begin // C.JAL / C.J
                instr32_o = {jimm[20], jimm[10:1], jimm[11], jimm[19:12],
                             (ci_word_i.ci.funct3 == 3'b101) ? reg_zero : reg_ra,
                             opc_jal};
            end

            3'b110, 3'b111: begin // C.BEQZ / C.BNEZ
                instr32_o = {bimm[12], bimm[10:5], reg_zero, rs1_p,
                             (ci_word_i.ci.funct3 == 3'b110) ? f3_beq : f3_bne,
                             bimm[4:1], bimm[11], opc_branch};
            end

            3'b010: begin // C.LI
                instr32_o = {imm12, reg_zero, f3_add, rfield, opc_op_imm};
            end

            3'b011: begin
                if (rfield == reg_sp) begin // C.ADDI16SP
                    instr32_o = {imm16sp, reg_sp, f3_add, reg_sp, opc_op_imm};
                end else begin // C.LUI
                    instr32_o = {imm20, rfield, opc_lui};
                end
                if ((sbit == 1'b0) && (lfield == 5'b00000)) begin
                    illegal_o = 1'b1; // Reserved, nzimm = 0
                end
            end

            3'b000: begin // C.ADDI, C.NOP when rd = x0
                instr32_o = {imm12, rfield, f3_add, rfield, opc_op_imm};
            end

            default: begin // 100, ALU group on x8..x15
                unique case (ci_word_i.cs.imm_hi[1:0])
                    2'b00, 2'b01: begin // C.SRLI / C.SRAI
                        instr32_o = {ci_word_i.cs.imm_hi[0] ? f7_alt : f7_base, lfield,
                                     rs1_p, f3_sr, rs1_p, opc_op_imm};
                        if (sbit) begin
                            illegal_o = 1'b1; // shamt[5] set on RV32
                        end
                    end

                    2'b10: begin // C.ANDI
                        instr32_o = {imm12, rs1_p, f3_and, rs1_p, opc_op_imm};
                    end

                    default: begin
                        unique case (ci_word_i.cs.imm_lo)
                            2'b00:   instr32_o = {f7_alt, rs2_p, rs1_p, f3_add,
                                                  rs1_p, opc_op}; // C.SUB
                            2'b01:   instr32_o = {f7_base, rs2_p, rs1_p, f3_xor,
                                                  rs1_p, opc_op}; // C.XOR
                            2'b10:   instr32_o = {f7_base, rs2_p, rs1_p, f3_or,
                                                  rs1_p, opc_op}; // C.OR
                            default: instr32_o = {f7_base, rs2_p, rs1_p, f3_and,
                                                  rs1_p, opc_op}; // C.AND
                        endcase
                    end
                endcase
            end
        endcase
    end

endmodule

// File: design/rvc_quadrant2.sv
// ------------------------------------------------------------
// RVC quadrant 2 expander
// SLLI, stack loads/stores, JR/JALR, MV, ADD and EBREAK
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_quadrant2 (
    input  rvc_pkg::rvc_word_u     ci_word_i,
    output logic [`RVC_ILEN-1:0]   instr32_o,
    output logic                   illegal_o
);

    import rvc_pkg::*;

    logic        sbit;
    logic [4:0]  rfield; // rd / rs1
    logic [4:0]  lfield; // rs2 or immediate
    logic [11:0] lw_off; // Stack load offset
    logic [11:0] sw_off; // Stack store offset

    assign sbit   = ci_word_i.ci.imm_hi;
    assign rfield = ci_word_i.ci.rd_rs1;
    assign lfield = ci_word_i.ci.lo;

    // off[7:6] = b3:2, [5] = b12, [4:2] = b6:4
    assign lw_off = {4'b0000, lfield[1:0], sbit, lfield[4:2], 2'b00};
    // off[7:6] = b8:7, [5:2] = b12:9
    assign sw_off = {4'b0000, rfield[1:0], sbit, rfield[4:2], 2'b00};

    always_comb begin
        instr32_o = '0;
        illegal_o = 1'b0;

        unique case (ci_word_i.ci.funct3)
            3'b000: begin // C.SLLI
                instr32_o = {f7_base, lfield, rfield, f3_sll, rfield, opc_op_imm};
                if (sbit) begin
                    illegal_o = 1'b1;
                end
            end

            3'b010, 3'b011: begin // C.LWSP / C.FLWSP
                instr32_o = {lw_off, reg_sp, f3_lw, rfield, opc_load};
                if ((ci_word_i.ci.funct3 == 3'b011) && (`RVC_FPU_ENABLE == 1'b0)) begin
                    illegal_o = 1'b1;
                end
            end

            3'b110, 3'b111: begin // C.SWSP / C.FSWSP
                instr32_o = {sw_off[11:5], lfield, reg_sp, f3_sw, sw_off[4:0], opc_store};
                if ((ci_word_i.ci.funct3 == 3'b111) && (`RVC_FPU_ENABLE == 1'b0)) begin
                    illegal_o = 1'b1;
                end
            end

            // ------------------------------------------------------------
            // Jump / move / add group
            // ------------------------------------------------------------
            default: begin
                if (!sbit) begin
                    if (lfield == 5'b00000) begin // C.JR
                        instr32_o = {12'h000, rfield, 3'b000, reg_zero, opc_jalr};
                    end else begin // C.MV
                        instr32_o = {f7_base, lfield, reg_zero, f3_add, rfield, opc_op};
                    end
                end else if (lfield == 5'b00000) begin
                    if (rfield == 5'b00000) begin // C.EBREAK
                        instr32_o = {f12_ebreak, 13'h0000, opc_system};
                    end else begin // C.JALR
                        instr32_o = {12'h000, rfield, 3'b000, reg_ra, opc_jalr};
                    end
                end else begin // C.ADD
                    instr32_o = {f7_base, lfield, rfield, f3_add, rfield, opc_op};
                end

                // C.FLDSP and C.FSDSP
                if ((ci_word_i.ci.funct3 == 3'b001) || (ci_word_i.ci.funct3 == 3'b101)) begin
                    illegal_o = 1'b1;
                end
            end
        endcase
    end

endmodule

// File: design/rvc_expander.sv
// ------------------------------------------------------------
// RVC expander top
// Quadrant select and fetch-to-decode output register
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_expander (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   ci_valid_i,
    input  rvc_pkg::rvc_word_u     ci_instr16_i,
    output logic                   ci_valid_o,
    output logic                   ci_illegal_o,
    output logic [`RVC_ILEN-1:0]   ci_instr32_o
);

    logic [`RVC_ILEN-1:0] q0_instr;
    logic [`RVC_ILEN-1:0] q1_instr;
    logic [`RVC_ILEN-1:0] q2_instr;
    logic [`RVC_ILEN-1:0] sel_instr;
    logic                 q0_illegal;
    logic                 q1_illegal;
    logic                 q2_illegal;
    logic                 sel_illegal;

    // ------------------------------------------------------------
    // Quadrant decoders
    // ------------------------------------------------------------
    rvc_quadrant0 u_quadrant0 (
        .ci_word_i (ci_instr16_i),
        .instr32_o (q0_instr),
        .illegal_o (q0_illegal)
    );

    rvc_quadrant1 u_quadrant1 (
        .ci_word_i (ci_instr16_i),
        .instr32_o (q1_instr),
        .illegal_o (q1_illegal)
    );

    rvc_quadrant2 u_quadrant2 (
        .ci_word_i (ci_instr16_i),
        .instr32_o (q2_instr),
        .illegal_o (q2_illegal)
    );

    // Quadrant 3 never arrives, shares the quadrant 2 path
    always_comb begin
        unique case (ci_instr16_i.ci.quad)
            2'b00: begin
                sel_instr   = q0_instr;
                sel_illegal = q0_illegal;
            end
            2'b01: begin
                sel_instr   = q1_instr;
                sel_illegal = q1_illegal;
            end
            default: begin
                sel_instr   = q2_instr;
                sel_illegal = q2_illegal;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Output register stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ci_valid_o   <= 1'b0;
            ci_illegal_o <= 1'b0;
            ci_instr32_o <= '0;
        end else begin
            ci_valid_o <= ci_valid_i;
            if (ci_valid_i) begin // Hold on idle cycles
                ci_illegal_o <= sel_illegal;
                ci_instr32_o <= sel_instr;
            end
        end
    end

endmodule

// File: verif/rvc_expander_assertions.sv
// ------------------------------------------------------------
// RVC expander checker bound to the top level
// Concurrent assertions on timing and expansion rules
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_expander_assertions (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   in_valid_i,
    input  rvc_pkg::rvc_word_u     in_word_i,
    input  logic                   out_valid_i,
    input  logic                   out_illegal_i,
    input  logic [`RVC_ILEN-1:0]   out_instr32_i
);

    import rvc_pkg::*;

    // Base opcodes as listed in the RV32I encoding tables
    localparam logic [6:0] load_opcode   = 7'b0000011;
    localparam logic [6:0] store_opcode  = 7'b0100011;
    localparam logic [6:0] opimm_opcode  = 7'b0010011;
    localparam logic [6:0] op_opcode     = 7'b0110011;
    localparam logic [6:0] jal_opcode    = 7'b1101111;

    int unsigned err_count = 0;

    logic       prev_valid;
    rvc_word_u  prev_word;   // Word behind the current output
    logic [4:0] exp_base;    // x8 + primed rs1

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_valid <= 1'b0;
            prev_word  <= '0;
        end else begin
            prev_valid <= in_valid_i;
            prev_word  <= in_word_i;
        end
    end

    assign exp_base = 5'd8 + {2'b00, prev_word.cs.rs1_p};

    // ------------------------------------------------------------
    // Timing and reset
    // ------------------------------------------------------------
    reset_state: assert property (@(posedge clk_i)
        !arst_n_i |-> (!out_valid_i && !out_illegal_i && (out_instr32_i == '0))
    ) else begin
        $error("outputs not cleared during reset");
        err_count = err_count + 1;
    end

    valid_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i == prev_valid
    ) else begin
        $error("ci_valid_o does not follow ci_valid_i of the previous cycle");
        err_count = err_count + 1;
    end

    // Legal results are 32-bit encodings
    width_bits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && !out_illegal_i) |-> (out_instr32_i[1:0] == 2'b11)
    ) else begin
        $error("legal output without 32-bit encoding marker");
        err_count = err_count + 1;
    end

    // ------------------------------------------------------------
    // Illegal words
    // ------------------------------------------------------------
    zero_word_illegal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && (prev_word == '0)) |-> out_illegal_i
    ) else begin
        $error("all-zero word not flagged illegal");
        err_count = err_count + 1;
    end

    fpu_forms_illegal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && (`RVC_FPU_ENABLE == 1'b0) && !prev_word.ci.quad[0] &&
         (prev_word.ci.funct3 inside {3'b011, 3'b111})) |-> out_illegal_i
    ) else begin
        $error("float load/store form not flagged illegal");
        err_count = err_count + 1;
    end

    // ------------------------------------------------------------
    // Expansion fields
    // ------------------------------------------------------------
    q0_load_store: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && !out_illegal_i && (prev_word.cs.quad == 2'b00) &&
         (prev_word.cs.funct3 inside {3'b010, 3'b110})) |->
        ((out_instr32_i[6:0] ==
          ((prev_word.cs.funct3 == 3'b110) ? store_opcode : load_opcode)) &&
         (out_instr32_i[19:15] == exp_base))
    ) else begin
        $error("C.LW/C.SW opcode or base register wrong");
        err_count = err_count + 1;
    end

    addi_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && (prev_word.ci.quad == 2'b01) && (prev_word.ci.funct3 == 3'b000)) |->
        ((out_instr32_i[6:0] == opimm_opcode) &&
         (out_instr32_i[11:7] == prev_word.ci.rd_rs1) &&
         (out_instr32_i[19:15] == prev_word.ci.rd_rs1) &&
         (out_instr32_i[31] == prev_word.ci.imm_hi))
    ) else begin
        $error("C.ADDI expansion fields wrong");
        err_count = err_count + 1;
    end

    mv_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && (prev_word.ci.quad == 2'b10) && (prev_word.ci.funct3 == 3'b100) &&
         !prev_word.ci.imm_hi && (prev_word.ci.lo != 5'd0)) |->
        ((out_instr32_i[6:0] == op_opcode) && (out_instr32_i[19:15] == 5'd0))
    ) else begin
        $error("C.MV expansion fields wrong");
        err_count = err_count + 1;
    end

    jump_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && (prev_word.ci.quad == 2'b01) &&
         (prev_word.ci.funct3 inside {3'b001, 3'b101})) |->
        ((out_instr32_i[6:0] == jal_opcode) &&
         (out_instr32_i[11:7] == ((prev_word.ci.funct3 == 3'b101) ? 5'd0 : 5'd1)) &&
         (out_instr32_i[31] == prev_word.ci.imm_hi))
    ) else begin
        $error("C.J/C.JAL expansion fields wrong");
        err_count = err_count + 1;
    end

endmodule

// File: verif/rvc_expander_tb.sv
// ------------------------------------------------------------
// RVC expander testbench
// LFSR stimulus, bound assertions do the checking
// ------------------------------------------------------------

`timescale 1ns/10ps

`include "rvc_settings.svh"

module rvc_expander_tb;

    import rvc_pkg::*;

    localparam int num_words  = 600;
    localparam int max_cycles = 700;   // Reset, zero word, 600 slots and drain

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 ci_valid_i;
    rvc_word_u            ci_instr16_i;
    logic                 ci_valid_o;
    logic                 ci_illegal_o;
    logic [`RVC_ILEN-1:0] ci_instr32_o;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          tb_errors;
    int          assert_errors;

    rvc_expander DUT (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .ci_valid_i   (ci_valid_i),
        .ci_instr16_i (ci_instr16_i),
        .ci_valid_o   (ci_valid_o),
        .ci_illegal_o (ci_illegal_o),
        .ci_instr32_o (ci_instr32_o)
    );

    bind rvc_expander rvc_expander_assertions u_assertions (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (ci_valid_i),
        .in_word_i     (ci_instr16_i),
        .out_valid_i   (ci_valid_o),
        .out_illegal_i (ci_illegal_o),
        .out_instr32_i (ci_instr32_o)
    );

    always #20 clk_i = ~clk_i; // 40 ns period

    // ------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA3000000;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit
    task automatic draw_word(output logic [15:0] word);
        for (int i = 0; i < 16; i++) begin
            word[i]    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk_i);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        logic [15:0] word;

        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        ci_valid_i   = 1'b0;
        ci_instr16_i = '0;
        lfsr_state   = 32'd79962;
        tb_errors    = 0;

        repeat (3) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;

        if (ci_valid_o !== 1'b0) begin
            $display("CHECK FAILED at %0t: ci_valid_o = %b, expected %b",
                     $time, ci_valid_o, 1'b0);
            tb_errors = tb_errors + 1;
        end

        // Directed all-zero word
        ci_valid_i   = 1'b1;
        ci_instr16_i = '0;

        for (int slot = 0; slot < num_words; slot++) begin
            @(posedge clk_i);
            #2;
            draw_word(word);
            ci_instr16_i = word;
            ci_valid_i   = ((slot % 8) != 7); // Idle on every eighth cycle
        end

        @(posedge clk_i);
        #2;
        ci_valid_i = 1'b0;
        repeat (2) @(posedge clk_i); // Let the last result be checked
        #2;

        assert_errors = DUT.u_assertions.err_count;
        $display("Error count: testbench %0d, assertions %0d", tb_errors, assert_errors);
        if ((tb_errors == 0) && (assert_errors == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: rvc_expander.f
+incdir+design
design/rvc_pkg.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rvc_expander.sv
verif/rvc_expander_assertions.sv
verif/rvc_expander_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the RVC expander testbench with Verilator, run it and check the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rvc_expander.f \
    --top-module rvc_expander_tb -o rvc_expander_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the runtime error limit so every assertion failure is counted
sim_output=$(./obj_dir/rvc_expander_sim +verilator+error+limit+10000)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
